/* flist.f */
logic/const_pack.sv
logic/chan_coef_if.sv
logic/chan_resp_regs.sv
logic/emu_noise_gen.sv
logic/adc_slice.sv
logic/analog_core.sv
logic/test_analog_core.sv
sim/tb_test_analog_core.sv

/* Makefile */
TOP = tb_test_analog_core

.PHONY: compile run test clean

compile:
	verilator --binary --top-module $(TOP) -f flist.f --Mdir obj_dir -o sim_tb

run: compile
	./obj_dir/sim_tb | tee sim.log

test: run
	@if grep -q "TB FAILED" sim.log; then \
		echo "simulation reported failure"; \
		exit 1; \
	fi
	@grep -q "TB PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

/* sim/tb_test_analog_core.sv */
module tb_test_analog_core;
    localparam int ADC_SHIFT = 8;
    localparam int NTI = const_pack::Nti;
    localparam int NADC = const_pack::Nadc;
    localparam int MAG_MAX = (1 << NADC) - 1;
    localparam int FINE_MAX = (1 << const_pack::Npi_fine) - 1;
    localparam int PRELOAD = const_pack::Nbin * const_pack::Ntap;
    localparam int PIPE = 4;
    localparam int NROW = 8;

    typedef struct packed {
        logic                                               we;
        logic [const_pack::Chan_addr_width-1:0]             waddr;
        logic [const_pack::FUNC_DATA_WIDTH-1:0]             wcoef;
        logic [const_pack::FUNC_DATA_WIDTH-1:0]             wslope;
        logic [const_pack::Nout-1:0][const_pack::Npi-1:0]   pi;
        logic [const_pack::Noise_width-1:0]                 noise;
        logic [const_pack::Jitter_width-1:0]                jitter;
        int                                                 reps;
    } row_t;

    // expected result of one word, exact or as a range
    typedef struct packed {
        logic                           check;
        logic                           bounded;
        logic [NTI-1:0][NADC-1:0]       mag_lo;
        logic [NTI-1:0][NADC-1:0]       mag_hi;
        logic [NTI-1:0]                 sign_hi;
        logic [NTI-1:0]                 sign_lo;
    } exp_t;

    // pi codes, group 3 first
    localparam logic [3:0][8:0] PI_ZERO = '0;
    localparam logic [3:0][8:0] PI_MIX = {{3'd7, 6'd5}, {3'd5, 6'd63}, {3'd3, 6'd40}, {3'd1, 6'd17}};
    localparam logic [3:0][8:0] PI_NOISY = {{3'd2, 6'd0}, {3'd6, 6'd63}, {3'd4, 6'd30}, {3'd0, 6'd10}};

    logic                                   clk;
    logic                                   rst_n_i;
    logic [NTI-1:0]                         bits_i;
    logic [const_pack::Npi-1:0]             ctl_pi_0_i;
    logic [const_pack::Npi-1:0]             ctl_pi_1_i;
    logic [const_pack::Npi-1:0]             ctl_pi_2_i;
    logic [const_pack::Npi-1:0]             ctl_pi_3_i;
    logic [const_pack::Jitter_width-1:0]    jitter_rms_int_i;
    logic [const_pack::Noise_width-1:0]     noise_rms_int_i;
    logic [const_pack::FUNC_DATA_WIDTH-1:0] chan_wdata_0_i;
    logic [const_pack::FUNC_DATA_WIDTH-1:0] chan_wdata_1_i;
    logic [const_pack::Chan_addr_width-1:0] chan_waddr_i;
    logic                                   chan_we_i;
    wire  [NADC-1:0]                        mag_out [NTI];
    wire  [NTI-1:0]                         sign_out;

    row_t        rows [NROW];
    exp_t        exp_q [$];
    int          m_coef [PRELOAD];
    int          m_slope [PRELOAD];
    logic [NTI-1:0] prev_word;
    logic [31:0] lfsr_q;
    int          mismatch_cnt;
    int          bound_cnt;
    int          cycle_cnt;
    int          cycle_limit;

    test_analog_core #(
        .ADC_SHIFT (ADC_SHIFT)
    ) DUT (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .bits_i           (bits_i),
        .ctl_pi_0_i       (ctl_pi_0_i),
        .ctl_pi_1_i       (ctl_pi_1_i),
        .ctl_pi_2_i       (ctl_pi_2_i),
        .ctl_pi_3_i       (ctl_pi_3_i),
        .jitter_rms_int_i (jitter_rms_int_i),
        .noise_rms_int_i  (noise_rms_int_i),
        .chan_wdata_0_i   (chan_wdata_0_i),
        .chan_wdata_1_i   (chan_wdata_1_i),
        .chan_waddr_i     (chan_waddr_i),
        .chan_we_i        (chan_we_i),
        .adder_out_0_o    (mag_out[0]),
        .adder_out_1_o    (mag_out[1]),
        .adder_out_2_o    (mag_out[2]),
        .adder_out_3_o    (mag_out[3]),
        .adder_out_4_o    (mag_out[4]),
        .adder_out_5_o    (mag_out[5]),
        .adder_out_6_o    (mag_out[6]),
        .adder_out_7_o    (mag_out[7]),
        .adder_out_8_o    (mag_out[8]),
        .adder_out_9_o    (mag_out[9]),
        .adder_out_10_o   (mag_out[10]),
        .adder_out_11_o   (mag_out[11]),
        .adder_out_12_o   (mag_out[12]),
        .adder_out_13_o   (mag_out[13]),
        .adder_out_14_o   (mag_out[14]),
        .adder_out_15_o   (mag_out[15]),
        .sign_out_o       (sign_out)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // noise-free four-tap sum of slice k at one fine code
    function automatic int tap_sum(input int k, input logic [NTI-1:0] cur,
                                   input logic [NTI-1:0] prev, input int bin, input int fine);
        int acc;
        int c;
        int idx;
        int a;
        logic b;
        acc = 0;
        for (int t = 0; t < const_pack::Ntap; t++) begin
            idx = k - t;
            a = bin * const_pack::Ntap + t;
            b = (idx >= 0) ? cur[idx] : prev[NTI + idx];
            c = m_coef[a] + ((m_slope[a] * fine) >>> const_pack::Npi_fine);
            acc += b ? c : -c;
        end
        return acc;
    endfunction

    function automatic int adc_mag(input int s);
        int a;
        a = (s < 0) ? -s : s;
        a = a >>> ADC_SHIFT;
        return (a > MAG_MAX) ? MAG_MAX : a;
    endfunction

    task automatic check_reset_state();
        for (int k = 0; k < NTI; k++) begin
            if (mag_out[k] != '0) begin
                $display("MISMATCH adder_out_%0d_o expected %h got %h", k, 8'h00, mag_out[k]);
                mismatch_cnt++;
            end
        end
        if (sign_out != '0) begin
            $display("MISMATCH sign_out_o expected %h got %h", 16'h0000, sign_out);
            mismatch_cnt++;
        end
    endtask

    task automatic check_word(input exp_t e);
        for (int k = 0; k < NTI; k++) begin
            if (e.check && !e.bounded) begin
                if (mag_out[k] != e.mag_lo[k]) begin
                    $display("MISMATCH adder_out_%0d_o expected %h got %h",
                             k, e.mag_lo[k], mag_out[k]);
                    mismatch_cnt++;
                end
                if (sign_out[k] != e.sign_hi[k]) begin
                    $display("MISMATCH sign_out_o[%0d] expected %h got %h",
                             k, e.sign_hi[k], sign_out[k]);
                    mismatch_cnt++;
                end
            end else if (e.check) begin
                if (mag_out[k] < e.mag_lo[k] || mag_out[k] > e.mag_hi[k]) begin
                    $display("slice %0d magnitude %0d is outside the noise range %0d to %0d",
                             k, mag_out[k], e.mag_lo[k], e.mag_hi[k]);
                    bound_cnt++;
                end
                if ((e.sign_hi[k] && !sign_out[k]) || (e.sign_lo[k] && sign_out[k])) begin
                    $display("slice %0d sign flipped although the sum is beyond the noise bound",
                             k);
                    bound_cnt++;
                end
            end
        end
    endtask

    // one word: drive, predict, and check the word from three cycles back
    task automatic run_cycle(input row_t r, input logic do_write, input logic check);
        logic [NTI-1:0] word;
        logic [const_pack::Npi-1:0] pi;
        exp_t e;
        int bin;
        int fine;
        int f_lo;
        int f_hi;
        int s;
        int lo;
        int hi;
        int mlo;
        int mhi;
        for (int i = 0; i < NTI; i++) begin
            word[i] = lfsr_q[0];
            lfsr_q = lfsr_step(lfsr_q);
        end
        @(posedge clk);
        bits_i <= word;
        ctl_pi_0_i <= r.pi[0];
        ctl_pi_1_i <= r.pi[1];
        ctl_pi_2_i <= r.pi[2];
        ctl_pi_3_i <= r.pi[3];
        noise_rms_int_i <= r.noise;
        jitter_rms_int_i <= r.jitter;
        chan_we_i <= do_write & r.we;
        chan_waddr_i <= r.waddr;
        chan_wdata_0_i <= r.wcoef;
        chan_wdata_1_i <= r.wslope;
        e = '0;
        e.check = check;
        e.bounded = (r.noise != '0) || (r.jitter != '0);
        for (int k = 0; k < NTI; k++) begin
            pi = r.pi[k / (NTI / const_pack::Nout)];
            bin = int'(pi[const_pack::Npi-1:const_pack::Npi_fine]);
            fine = int'(pi[const_pack::Npi_fine-1:0]);
            f_lo = (fine - int'(r.jitter) < 0) ? 0 : fine - int'(r.jitter);
            f_hi = (fine + int'(r.jitter) > FINE_MAX) ? FINE_MAX : fine + int'(r.jitter);
            lo = tap_sum(k, word, prev_word, bin, f_lo);
            hi = lo;
            for (int f = f_lo + 1; f <= f_hi; f++) begin
                s = tap_sum(k, word, prev_word, bin, f);
                lo = (s < lo) ? s : lo;
                hi = (s > hi) ? s : hi;
            end
            lo = lo - int'(r.noise);
            hi = hi + int'(r.noise);
            if (lo >= 0) begin
                mlo = adc_mag(lo);
                mhi = adc_mag(hi);
            end else if (hi < 0) begin
                mlo = adc_mag(hi);
                mhi = adc_mag(lo);
            end else begin
                mlo = 0;
                mhi = (adc_mag(lo) > adc_mag(hi)) ? adc_mag(lo) : adc_mag(hi);
            end
            // one lsb of slack once noise or jitter is on
            if (e.bounded) begin
                mlo = (mlo > 0) ? mlo - 1 : 0;
                mhi = (mhi < MAG_MAX) ? mhi + 1 : MAG_MAX;
            end
            e.mag_lo[k] = NADC'(mlo);
            e.mag_hi[k] = NADC'(mhi);
            e.sign_hi[k] = (lo >= 0);
            e.sign_lo[k] = (hi < 0);
        end
        // a write reaches only the words after the one sampled with it
        if (do_write && r.we && int'(r.waddr) < PRELOAD) begin
            m_coef[int'(r.waddr)] = int'($signed(r.wcoef));
            m_slope[int'(r.waddr)] = int'($signed(r.wslope));
        end
        prev_word = word;
        exp_q.push_back(e);
        @(negedge clk);
        if (exp_q.size() == PIPE) begin
            check_word(exp_q.pop_front());
        end
    endtask

    initial begin
        cycle_cnt = 0;
        wait (cycle_limit > 0);
        while (cycle_cnt < cycle_limit) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout after %0d cycles, the stimulus did not complete", cycle_cnt);
        $display("errors: %0d mismatches, %0d bound violations", mismatch_cnt, bound_cnt);
        $display("TB FAILED");
        $finish;
    end

    initial begin
        row_t r;
        int total;
        rst_n_i = 1'b0;
        bits_i = '0;
        ctl_pi_0_i = '0;
        ctl_pi_1_i = '0;
        ctl_pi_2_i = '0;
        ctl_pi_3_i = '0;
        jitter_rms_int_i = '0;
        noise_rms_int_i = '0;
        chan_wdata_0_i = '0;
        chan_wdata_1_i = '0;
        chan_waddr_i = '0;
        chan_we_i = 1'b0;
        mismatch_cnt = 0;
        bound_cnt = 0;
        prev_word = '0;
        lfsr_q = 32'h4e594341;
        cycle_limit = 0;
        for (int a = 0; a < PRELOAD; a++) begin
            m_coef[a] = 0;
            m_slope[a] = 0;
        end

        // we, addr, coef, slope, pi, noise, jitter, reps
        rows[0] = '{1'b0, 9'd0, 18'd0, 18'd0, PI_ZERO, 11'd0, 7'd0, 40};
        rows[1] = '{1'b0, 9'd0, 18'd0, 18'd0, PI_MIX, 11'd0, 7'd0, 40};
        rows[2] = '{1'b1, 9'd12, 18'sd20000, -18'sd1000, PI_MIX, 11'd0, 7'd0, 12};
        rows[3] = '{1'b1, 9'd300, 18'sd100000, 18'sd50000, PI_MIX, 11'd0, 7'd0, 12};
        rows[4] = '{1'b1, 9'd0, 18'sd131071, 18'd0, PI_ZERO, 11'd0, 7'd0, 16};
        rows[5] = '{1'b1, 9'd0, 18'sd6000, 18'sd250, PI_NOISY, 11'd300, 7'd20, 48};
        rows[6] = '{1'b0, 9'd0, 18'd0, 18'd0, PI_NOISY, 11'd2047, 7'd127, 40};
        rows[7] = '{1'b0, 9'd0, 18'd0, 18'd0, PI_MIX, 11'd0, 7'd0, 24};

        total = 0;
        for (int i = 0; i < NROW; i++) begin
            total += rows[i].reps;
        end
        cycle_limit = 16 + 1 + PRELOAD + total + PIPE + 100;

        // reset, outputs must stay cleared
        repeat (16) begin
            @(posedge clk);
            @(negedge clk);
            check_reset_state();
        end
        @(posedge clk);
        rst_n_i <= 1'b1;
        @(negedge clk);
        check_reset_state();

        // table load, pattern depends on the whole address
        for (int a = 0; a < PRELOAD; a++) begin
            r = '0;
            r.we = 1'b1;
            r.waddr = 9'(a);
            r.wcoef = 18'(((a * 37 + 11) % 64 - 32) * 400);
            r.wslope = 18'(((a * 53 + 5) % 32 - 16) * 300);
            r.reps = 1;
            run_cycle(r, 1'b1, 1'b1);
        end

        for (int i = 0; i < NROW; i++) begin
            for (int n = 0; n < rows[i].reps; n++) begin
                run_cycle(rows[i], n == 0, 1'b1);
            end
        end

        // flush the pipeline
        r = rows[NROW-1];
        repeat (PIPE - 1) begin
            run_cycle(r, 1'b0, 1'b0);
        end

        $display("errors: %0d mismatches, %0d bound violations", mismatch_cnt, bound_cnt);
        if (mismatch_cnt == 0 && bound_cnt == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end
endmodule

/* logic/test_analog_core.sv */
module test_analog_core #(
    parameter int          ADC_SHIFT      = 8,
    parameter int          TAPS_PER_GROUP = const_pack::Nti / const_pack::Nout,
    parameter logic [31:0] LFSR_SEED_BASE = 32'h5eed_1234
) (
    // emulator clock and reset
    input  logic                                  clk,
    input  logic                                  rst_n_i,

    // transmitted word
    input  logic [const_pack::Nti-1:0]             bits_i,

    // PI codes, one per group
    input  logic [const_pack::Npi-1:0]             ctl_pi_0_i,
    input  logic [const_pack::Npi-1:0]             ctl_pi_1_i,
    input  logic [const_pack::Npi-1:0]             ctl_pi_2_i,
    input  logic [const_pack::Npi-1:0]             ctl_pi_3_i,

    // jitter and noise commands
    input  logic [const_pack::Jitter_width-1:0]    jitter_rms_int_i,
    input  logic [const_pack::Noise_width-1:0]     noise_rms_int_i,

    // pulse response writes
    input  logic [const_pack::FUNC_DATA_WIDTH-1:0] chan_wdata_0_i,
    input  logic [const_pack::FUNC_DATA_WIDTH-1:0] chan_wdata_1_i,
    input  logic [const_pack::Chan_addr_width-1:0] chan_waddr_i,
    input  logic                                  chan_we_i,

    // ADC magnitudes
    output logic [const_pack::Nadc-1:0]            adder_out_0_o,
    output logic [const_pack::Nadc-1:0]            adder_out_1_o,
    output logic [const_pack::Nadc-1:0]            adder_out_2_o,
    output logic [const_pack::Nadc-1:0]            adder_out_3_o,
    output logic [const_pack::Nadc-1:0]            adder_out_4_o,
    output logic [const_pack::Nadc-1:0]            adder_out_5_o,
    output logic [const_pack::Nadc-1:0]            adder_out_6_o,
    output logic [const_pack::Nadc-1:0]            adder_out_7_o,
    output logic [const_pack::Nadc-1:0]            adder_out_8_o,
    output logic [const_pack::Nadc-1:0]            adder_out_9_o,
    output logic [const_pack::Nadc-1:0]            adder_out_10_o,
    output logic [const_pack::Nadc-1:0]            adder_out_11_o,
    output logic [const_pack::Nadc-1:0]            adder_out_12_o,
    output logic [const_pack::Nadc-1:0]            adder_out_13_o,
    output logic [const_pack::Nadc-1:0]            adder_out_14_o,
    output logic [const_pack::Nadc-1:0]            adder_out_15_o,

    // ADC signs
    output logic [const_pack::Nti-1:0]             sign_out_o
);
    logic [const_pack::Npi-1:0]  ctl_pi [const_pack::Nout];
    logic [const_pack::Nadc-1:0] adder_out [const_pack::Nti];

    // gather PI codes
    assign ctl_pi[0] = ctl_pi_0_i;
    assign ctl_pi[1] = ctl_pi_1_i;
    assign ctl_pi[2] = ctl_pi_2_i;
    assign ctl_pi[3] = ctl_pi_3_i;

    // split magnitudes out to ports
    assign adder_out_0_o  = adder_out[0];
    assign adder_out_1_o  = adder_out[1];
    assign adder_out_2_o  = adder_out[2];
    assign adder_out_3_o  = adder_out[3];
    assign adder_out_4_o  = adder_out[4];
    assign adder_out_5_o  = adder_out[5];
    assign adder_out_6_o  = adder_out[6];
    assign adder_out_7_o  = adder_out[7];
    assign adder_out_8_o  = adder_out[8];
    assign adder_out_9_o  = adder_out[9];
    assign adder_out_10_o = adder_out[10];
    assign adder_out_11_o = adder_out[11];
    assign adder_out_12_o = adder_out[12];
    assign adder_out_13_o = adder_out[13];
    assign adder_out_14_o = adder_out[14];
    assign adder_out_15_o = adder_out[15];

    analog_core #(
        .ADC_SHIFT      (ADC_SHIFT),
        .TAPS_PER_GROUP (TAPS_PER_GROUP),
        .LFSR_SEED_BASE (LFSR_SEED_BASE)
    ) u_analog_core (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .rx_bits_i      (bits_i),
        .ctl_pi_i       (ctl_pi),
        .jitter_rms_i   (jitter_rms_int_i),
        .noise_rms_i    (noise_rms_int_i),
        .chan_wdata_0_i (chan_wdata_0_i),
        .chan_wdata_1_i (chan_wdata_1_i),
        .chan_waddr_i   (chan_waddr_i),
        .chan_we_i      (chan_we_i),
        .adder_out_o    (adder_out),
        .sign_out_o     (sign_out_o)
    );
endmodule

/* logic/analog_core.sv */
module analog_core #(
    parameter int          ADC_SHIFT      = 8,
    parameter int          TAPS_PER_GROUP = 4,
    parameter logic [31:0] LFSR_SEED_BASE = 32'h5eed_1234
) (
    input  logic                                  clk,
    input  logic                                  rst_n_i,
    input  logic [const_pack::Nti-1:0]             rx_bits_i,
    input  logic [const_pack::Npi-1:0]             ctl_pi_i [const_pack::Nout],
    input  logic [const_pack::Jitter_width-1:0]    jitter_rms_i,
    input  logic [const_pack::Noise_width-1:0]     noise_rms_i,
    input  logic [const_pack::FUNC_DATA_WIDTH-1:0] chan_wdata_0_i,
    input  logic [const_pack::FUNC_DATA_WIDTH-1:0] chan_wdata_1_i,
    input  logic [const_pack::Chan_addr_width-1:0] chan_waddr_i,
    input  logic                                  chan_we_i,
    output logic [const_pack::Nadc-1:0]            adder_out_o [const_pack::Nti],
    output logic [const_pack::Nti-1:0]             sign_out_o
);
    localparam int FSW = const_pack::Njitter + 1;
    localparam int NF = const_pack::Npi_fine;

    logic [const_pack::Nti-1:0]   bits_cur_q;
    logic [const_pack::Nti-1:0]   bits_prev_q;
    logic [2*const_pack::Nti-1:0] bit_hist;
    logic [const_pack::Npi-1:0]   ctl_q [const_pack::Nout];
    logic [FSW-1:0]               fine_sum [const_pack::Nout];
    logic [const_pack::Ntap-1:0]  lane_taps [const_pack::Nti];
    logic signed [const_pack::Nnoise-1:0]  noise [const_pack::Nti];
    logic signed [const_pack::Njitter-1:0] jitter [const_pack::Nout];

    chan_coef_if grp_if [const_pack::Nout] ();

    // bit history and PI codes, same edge as the noise and jitter registers
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            bits_cur_q  <= '0;
            bits_prev_q <= '0;
            for (int g = 0; g < const_pack::Nout; g++) begin
                ctl_q[g] <= '0;
            end
        end else begin
            bits_cur_q  <= rx_bits_i;
            bits_prev_q <= bits_cur_q;
            ctl_q       <= ctl_pi_i;
        end
    end

    // previous word in the low half, so bit k-t lands at Nti+k-t
    assign bit_hist = {bits_cur_q, bits_prev_q};

    for (genvar g = 0; g < const_pack::Nout; g++) begin : g_grp
        assign fine_sum[g] = {{(FSW-NF){1'b0}}, ctl_q[g][NF-1:0]}
                           + {jitter[g][const_pack::Njitter-1], jitter[g]};
        assign grp_if[g].phase_bin = ctl_q[g][const_pack::Npi-1:NF];
        // clamp keeps the jittered code inside its bin
        assign grp_if[g].fine = fine_sum[g][FSW-1] ? '0
                              : (|fine_sum[g][FSW-2:NF]) ? '1
                              : fine_sum[g][NF-1:0];
    end

    chan_resp_regs u_chan_resp_regs (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .wdata_0_i (chan_wdata_0_i),
        .wdata_1_i (chan_wdata_1_i),
        .waddr_i   (chan_waddr_i),
        .we_i      (chan_we_i),
        .grp_if    (grp_if)
    );

    emu_noise_gen #(
        .LFSR_SEED_BASE (LFSR_SEED_BASE)
    ) u_emu_noise_gen (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .noise_rms_i  (noise_rms_i),
        .jitter_rms_i (jitter_rms_i),
        .noise_o      (noise),
        .jitter_o     (jitter)
    );

    for (genvar k = 0; k < const_pack::Nti; k++) begin : g_slice
        for (genvar t = 0; t < const_pack::Ntap; t++) begin : g_tap
            assign lane_taps[k][t] = bit_hist[const_pack::Nti+k-t];
        end

        adc_slice #(
            .ADC_SHIFT (ADC_SHIFT)
        ) u_adc_slice (
            .clk     (clk),
            .rst_n_i (rst_n_i),
            .taps_i  (lane_taps[k]),
            .noise_i (noise[k]),
            .grp_if  (grp_if[k/TAPS_PER_GROUP]),
            .mag_o   (adder_out_o[k]),
            .sign_o  (sign_out_o[k])
        );
    end
endmodule

/* logic/adc_slice.sv */
module adc_slice #(
    parameter int ADC_SHIFT = 8
) (
    input  logic                                 clk,
    input  logic                                 rst_n_i,
    input  logic [const_pack::Ntap-1:0]          taps_i,
    input  logic signed [const_pack::Nnoise-1:0] noise_i,
    chan_coef_if.lane                            grp_if,
    output logic [const_pack::Nadc-1:0]          mag_o,
    output logic                                 sign_o
);
    localparam int FDW = const_pack::FUNC_DATA_WIDTH;
    localparam int PW = FDW + const_pack::Npi_fine + 1;
    localparam int SW = const_pack::Nsum + 1;

    logic signed [PW-1:0]              prod  [const_pack::Ntap];
    logic signed [PW-1:0]              adj   [const_pack::Ntap];
    logic signed [const_pack::Nsum-1:0] c_tap [const_pack::Ntap];
    logic signed [const_pack::Nsum-1:0] term  [const_pack::Ntap];
    logic signed [const_pack::Nsum-1:0] term_q [const_pack::Ntap];
    logic signed [const_pack::Nnoise-1:0] noise_q;
    logic signed [SW-1:0]              acc;
    logic [SW-1:0]                     mag_full;
    logic [SW-1:0]                     mag_sh;
    logic [const_pack::Nadc-1:0]       mag_next;

    // slope interpolation within the bin, then bit polarity
    always_comb begin
        for (int t = 0; t < const_pack::Ntap; t++) begin
            prod[t] = grp_if.slope[t] * $signed({1'b0, grp_if.fine});
            adj[t] = prod[t] >>> const_pack::Npi_fine;
            c_tap[t] = {{(const_pack::Nsum-FDW){grp_if.coef[t][FDW-1]}}, grp_if.coef[t]}
                     + adj[t][const_pack::Nsum-1:0];
            term[t] = taps_i[t] ? c_tap[t] : -c_tap[t];
        end
    end

    // stage 1
    always_ff @(posedge clk) begin
        term_q  <= term;
        noise_q <= noise_i;
    end

    // FIR sum plus noise, one guard bit over Nsum
    always_comb begin
        acc = {{(SW-const_pack::Nnoise){noise_q[const_pack::Nnoise-1]}}, noise_q};
        for (int t = 0; t < const_pack::Ntap; t++) begin
            acc = acc + {term_q[t][const_pack::Nsum-1], term_q[t]};
        end
    end

    // magnitude with saturation at full scale
    assign mag_full = acc[SW-1] ? -acc : acc;
    assign mag_sh = mag_full >> ADC_SHIFT;
    assign mag_next = (|mag_sh[SW-1:const_pack::Nadc]) ? '1 : mag_sh[const_pack::Nadc-1:0];

    // stage 2
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mag_o  <= '0;
            sign_o <= 1'b0;
        end else begin
            mag_o  <= mag_next;
            sign_o <= ~acc[SW-1];
        end
    end
endmodule

/* logic/emu_noise_gen.sv */
module emu_noise_gen #(
    parameter logic [31:0] LFSR_SEED_BASE = 32'h5eed_1234
) (
    input  logic                                 clk,
    input  logic                                 rst_n_i,
    input  logic [const_pack::Noise_width-1:0]   noise_rms_i,
    input  logic [const_pack::Jitter_width-1:0]  jitter_rms_i,
    output logic signed [const_pack::Nnoise-1:0]  noise_o  [const_pack::Nti],
    output logic signed [const_pack::Njitter-1:0] jitter_o [const_pack::Nout]
);
    localparam int NLANE = const_pack::Nti + const_pack::Nout;
    localparam logic [31:0] POLY = 32'h8020_0003;
    localparam logic [31:0] SEED_STEP = 32'h9e37_79b9;
    localparam int NPW = const_pack::Noise_width + const_pack::Nnoise;
    localparam int JPW = const_pack::Jitter_width + const_pack::Njitter;

    logic [31:0] lfsr_q [NLANE];

    for (genvar i = 0; i < NLANE; i++) begin : g_lane
        // spread the seeds so no two lanes track each other
        localparam logic [31:0] SEED = LFSR_SEED_BASE ^ 32'(SEED_STEP * (i + 1));

        always_ff @(posedge clk or negedge rst_n_i) begin
            if (!rst_n_i) begin
                lfsr_q[i] <= SEED;
            end else if (lfsr_q[i][0]) begin
                lfsr_q[i] <= (lfsr_q[i] >> 1) ^ POLY;
            end else begin
                lfsr_q[i] <= lfsr_q[i] >> 1;
            end
        end

        if (i < const_pack::Nti) begin : g_noise
            logic signed [NPW-1:0] prod;
            logic signed [NPW-1:0] prod_sh;

            // r * rms / 1024, never beyond rms
            assign prod = $signed(lfsr_q[i][const_pack::Noise_width-1:0])
                        * $signed({1'b0, noise_rms_i});
            assign prod_sh = prod >>> (const_pack::Noise_width - 1);

            always_ff @(posedge clk or negedge rst_n_i) begin
                if (!rst_n_i) begin
                    noise_o[i] <= '0;
                end else begin
                    noise_o[i] <= prod_sh[const_pack::Nnoise-1:0];
                end
            end
        end else begin : g_jitter
            logic signed [JPW-1:0] prod;
            logic signed [JPW-1:0] prod_sh;

            // r * rms / 64
            assign prod = $signed(lfsr_q[i][const_pack::Jitter_width-1:0])
                        * $signed({1'b0, jitter_rms_i});
            assign prod_sh = prod >>> (const_pack::Jitter_width - 1);

            always_ff @(posedge clk or negedge rst_n_i) begin
                if (!rst_n_i) begin
                    jitter_o[i-const_pack::Nti] <= '0;
                end else begin
                    jitter_o[i-const_pack::Nti] <= prod_sh[const_pack::Njitter-1:0];
                end
            end
        end
    end
endmodule

/* logic/chan_resp_regs.sv */
module chan_resp_regs (
    input  logic                                  clk,
    input  logic                                  rst_n_i,
    input  logic [const_pack::FUNC_DATA_WIDTH-1:0] wdata_0_i,
    input  logic [const_pack::FUNC_DATA_WIDTH-1:0] wdata_1_i,
    input  logic [const_pack::Chan_addr_width-1:0] waddr_i,
    input  logic                                  we_i,
    chan_coef_if.tbl                              grp_if [const_pack::Nout]
);
    localparam int DEPTH = const_pack::Nbin * const_pack::Ntap;
    localparam int AW = $clog2(DEPTH);
    localparam int TW = $clog2(const_pack::Ntap);

    // coefficient and slope per bin and tap
    logic signed [const_pack::FUNC_DATA_WIDTH-1:0] coef_mem  [DEPTH];
    logic signed [const_pack::FUNC_DATA_WIDTH-1:0] slope_mem [DEPTH];
    logic                                          wr_hit;
    logic                                          wr_q;
    logic [AW-1:0]                                 waddr_q;
    logic [const_pack::FUNC_DATA_WIDTH-1:0]        wdata_0_q;
    logic [const_pack::FUNC_DATA_WIDTH-1:0]        wdata_1_q;

    // addresses past the table are dropped
    assign wr_hit = we_i && (waddr_i < const_pack::Chan_addr_width'(DEPTH));

    // write lands one edge after the strobe
    // so the word sampled with it still reads the old entry
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_q      <= 1'b0;
            waddr_q   <= '0;
            wdata_0_q <= '0;
            wdata_1_q <= '0;
            for (int i = 0; i < DEPTH; i++) begin
                coef_mem[i]  <= '0;
                slope_mem[i] <= '0;
            end
        end else begin
            wr_q      <= wr_hit;
            waddr_q   <= waddr_i[AW-1:0];
            wdata_0_q <= wdata_0_i;
            wdata_1_q <= wdata_1_i;
            if (wr_q) begin
                coef_mem[waddr_q]  <= wdata_0_q;
                slope_mem[waddr_q] <= wdata_1_q;
            end
        end
    end

    // combinational lookup, address is bin*Ntap + tap
    for (genvar g = 0; g < const_pack::Nout; g++) begin : g_grp
        for (genvar t = 0; t < const_pack::Ntap; t++) begin : g_tap
            localparam logic [TW-1:0] TAP_IDX = TW'(t);

            assign grp_if[g].coef[t]  = coef_mem[{grp_if[g].phase_bin, TAP_IDX}];
            assign grp_if[g].slope[t] = slope_mem[{grp_if[g].phase_bin, TAP_IDX}];
        end
    end
endmodule

/* logic/chan_coef_if.sv */
interface chan_coef_if;
    // phase bin and jittered fine code of one PI group
    logic [const_pack::Npi-const_pack::Npi_fine-1:0] phase_bin;
    logic [const_pack::Npi_fine-1:0]                 fine;

    // tap set of the selected bin, newest bit first
    logic signed [const_pack::FUNC_DATA_WIDTH-1:0] coef  [const_pack::Ntap];
    logic signed [const_pack::FUNC_DATA_WIDTH-1:0] slope [const_pack::Ntap];

    // table side, looks up the tap set from the bin
    modport tbl (
        input  phase_bin,
        output coef,
        output slope
    );

    // slice side, consumes everything
    modport lane (
        input phase_bin,
        input fine,
        input coef,
        input slope
    );
endinterface

/* logic/const_pack.sv */
package const_pack;
    // interleaving and PI grouping
    localparam int Nti = 16;
    localparam int Nout = 4;

    // PI code split into phase bin and fine code
    localparam int Npi = 9;
    localparam int Npi_fine = 6;
    localparam int Nbin = 8;

    // ADC magnitude width
    localparam int Nadc = 8;

    // pulse response table geometry
    localparam int Ntap = 4;
    localparam int FUNC_DATA_WIDTH = 18;
    localparam int Chan_addr_width = 9;

    // signed width of the FIR sum
    localparam int Nsum = 21;

    // noise and jitter rms commands, plus the signed widths of the scaled values
    localparam int Noise_width = 11;
    localparam int Jitter_width = 7;
    localparam int Nnoise = Noise_width + 1;
    localparam int Njitter = Jitter_width + 1;
endpackage
